// ==== src/gprPkg.sv ====
package gprPkg;

	localparam int gprWidth = 64;
	localparam int gprCount = 32;
	localparam int laneCount = 3;	// lanes A, B, C
	localparam int portCount = 6;	// two read ports per lane
	localparam int immWidth = 33;	// imm32 plus sign-extend bit
	localparam int idxWidth = $clog2(gprCount);
	localparam int laneIdWidth = $clog2(laneCount);

	// special ids, top of the 6-bit space
	localparam logic [idxWidth:0] gprIdZzr = 6'h3F;
	localparam logic [idxWidth:0] gprIdImm = 6'h3E;

	// register id: raw word for compares, split view for bank addressing
	typedef union packed
	{
		logic [idxWidth:0] raw;
		struct packed
		{
			logic isSpecial;	// set for zzr, imm and the other non-gpr ids
			logic [idxWidth-1:0] idx;
		} fld;
	} gprId_t;

	// one lane result, dest id plus value
	typedef struct packed
	{
		gprId_t id;
		logic [gprWidth-1:0] val;
	} writeLane_t;

	// lane A at index 0
	typedef writeLane_t [laneCount-1:0] stageWrites_t;

	typedef gprId_t [portCount-1:0] portIds_t;

	typedef logic [portCount-1:0][gprWidth-1:0] portVals_t;

	typedef logic [laneCount-1:0][immWidth-1:0] laneImms_t;

endpackage

// ==== src/gprLiveTable.sv ====
`timescale 1ns/1ps

module gprLiveTable import gprPkg::*;
(
	input logic clock,
	input logic rstN,
	input logic [laneCount-1:0] writeEn,
	input logic [laneCount-1:0][idxWidth-1:0] writeIdx,
	input logic [portCount-1:0][idxWidth-1:0] readIdx,
	output logic [portCount-1:0][laneIdWidth-1:0] liveLane
);

	// which bank holds the newest copy of each register
	logic [laneIdWidth-1:0] liveTab [gprCount];

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			for (int r = 0; r < gprCount; r++)
				liveTab[r] <= '0;	// lane A, whose bank is zeroed
		end
		else
		begin
			// ascending lane order, so C beats B beats A on a collision
			for (int l = 0; l < laneCount; l++)
			begin
				if (writeEn[l])
					liveTab[writeIdx[l]] <= laneIdWidth'(l);
			end
		end
	end

	always_comb
	begin
		for (int p = 0; p < portCount; p++)
			liveLane[p] = liveTab[readIdx[p]];	// flat lookup, no bypass here
	end

	// only lanes 0..2 are ever recorded, code 3 would read a missing bank
	for (genvar p = 0; p < portCount; p++)
	begin : gLaneChk
		assert property (@(posedge clock) disable iff (!rstN)
			liveLane[p] != laneIdWidth'(3))
			else $error("live table port %0d names lane 3", p);
	end

	// writeback gate upstream has to hold off during reset
	assert property (@(posedge clock) !rstN |-> writeEn == '0)
		else $error("live table write enabled during reset");

endmodule

// ==== src/gprBankFile.sv ====
`timescale 1ns/1ps

module gprBankFile import gprPkg::*;
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic ex3Flush,
	input stageWrites_t wbLanes,	// ex3 results with lane A at 0
	input portIds_t readIds,
	output portVals_t bankVals
);

	logic wbOpen;	// stage level gate shared by all lanes
	logic [laneCount-1:0] writeEn;
	logic [laneCount-1:0][idxWidth-1:0] writeIdx;
	logic [portCount-1:0][idxWidth-1:0] readIdx;
	logic [portCount-1:0][laneIdWidth-1:0] liveLane;

	// one bank per lane and each lane writes only its own
	logic [gprWidth-1:0] bankMem [laneCount][gprCount];

	assign wbOpen = !hold && !ex3Flush;

	always_comb
	begin
		for (int l = 0; l < laneCount; l++)
		begin
			writeIdx[l] = wbLanes[l].id.fld.idx;
			writeEn[l] = wbOpen && !wbLanes[l].id.fld.isSpecial;	// zzr etc dropped
		end
		for (int p = 0; p < portCount; p++)
			readIdx[p] = readIds[p].fld.idx;
	end

	gprLiveTable liveTable
	(
		.clock(clock),
		.rstN(rstN),
		.writeEn(writeEn),
		.writeIdx(writeIdx),
		.readIdx(readIdx),
		.liveLane(liveLane)
	);

	always_ff @(posedge clock)
	begin
		for (int l = 0; l < laneCount; l++)
		begin
			if (writeEn[l])
				bankMem[l][writeIdx[l]] <= wbLanes[l].val;
		end
		// clear bank A where the live table points every reg after reset
		if (!rstN)
		begin
			for (int r = 0; r < gprCount; r++)
				bankMem[0][r] <= '0;
		end
	end

	// raw read of the live bank per port
	always_comb
	begin
		for (int p = 0; p < portCount; p++)
			bankVals[p] = bankMem[liveLane[p]][readIdx[p]];
	end

	// an X dest id would smear into the bank and the live table
	assert property (@(posedge clock) wbOpen |->
		!$isunknown({wbLanes[2].id, wbLanes[1].id, wbLanes[0].id}))
		else $error("writeback id unknown with write gate open");

endmodule

// ==== src/operandSelect.sv ====
`timescale 1ns/1ps

module operandSelect import gprPkg::*;
(
	input portIds_t readIds,
	input portVals_t bankVals,
	input laneImms_t laneImms,
	output portVals_t selVals,
	output logic [portCount-1:0] isConst
);

	always_comb
	begin
		logic [immWidth-1:0] imm;

		for (int p = 0; p < portCount; p++)
		begin
			imm = laneImms[p / 2];	// ports 2l and 2l+1 belong to lane l
			if (!readIds[p].fld.isSpecial)
			begin
				selVals[p] = bankVals[p];	// plain gpr
				isConst[p] = 1'b0;
			end
			else if (readIds[p].raw == gprIdImm)
			begin
				// bit 32 picks ones or zeros for the top half
				selVals[p] = {{(gprWidth - immWidth + 1){imm[immWidth-1]}},
					imm[immWidth-2:0]};
				isConst[p] = 1'b1;
			end
			else if (readIds[p].raw == gprIdZzr)
			begin
				selVals[p] = '0;
				isConst[p] = 1'b1;
			end
			else
			begin
				// other special ids read zero but stay non-const
				selVals[p] = '0;
				isConst[p] = 1'b0;
			end
		end
	end

endmodule

// ==== src/forwardNet.sv ====
`timescale 1ns/1ps

module forwardNet import gprPkg::*;
(
	input portIds_t readIds,
	input portVals_t selVals,
	input logic [portCount-1:0] isConst,
	input stageWrites_t ex1,
	input stageWrites_t ex2,
	input stageWrites_t ex3,
	output portVals_t readVals
);

	// one stage's lanes, walked C to A so lane A lands last and wins
	function automatic logic [gprWidth-1:0] pickStage(
		input logic [gprWidth-1:0] cur,
		input gprId_t id,
		input stageWrites_t st
	);
		logic [gprWidth-1:0] res;

		res = cur;
		for (int l = laneCount - 1; l >= 0; l--)
		begin
			if (st[l].id.raw == id.raw)
				res = st[l].val;
		end
		return res;
	endfunction

	always_comb
	begin
		logic [gprWidth-1:0] v;

		for (int p = 0; p < portCount; p++)
		begin
			v = selVals[p];
			// special ids never match, flush and hold are ignored here
			if (!isConst[p] && !readIds[p].fld.isSpecial)
			begin
				v = pickStage(v, readIds[p], ex3);	// oldest first
				v = pickStage(v, readIds[p], ex2);
				v = pickStage(v, readIds[p], ex1);	// youngest overrides
			end
			readVals[p] = v;
		end
	end

	// immediates and zzr have to pass through untouched
	always_comb
	begin
		for (int p = 0; p < portCount; p++)
		begin
			if (isConst[p])
				assert final (readVals[p] == selVals[p])
					else $error("constant port %0d was forwarded", p);
		end
	end

endmodule

// ==== src/regFile6r3w.sv ====
`timescale 1ns/1ps

module regFile6r3w import gprPkg::*;
(
	input logic clock,
	input logic rstN,
	input logic hold,	// freezes writeback
	input logic ex3Flush,	// cancels writeback
	input portIds_t readIds,
	input laneImms_t laneImms,
	input stageWrites_t ex1,
	input stageWrites_t ex2,
	input stageWrites_t ex3,
	output portVals_t readVals
);

	portVals_t bankVals;	// raw bank read per port
	portVals_t selVals;	// after gpr/imm/zzr decode
	logic [portCount-1:0] isConst;

	// ex3 is the writeback stage
	gprBankFile bankFile
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.ex3Flush(ex3Flush),
		.wbLanes(ex3),
		.readIds(readIds),
		.bankVals(bankVals)
	);

	operandSelect opSelect
	(
		.readIds(readIds),
		.bankVals(bankVals),
		.laneImms(laneImms),
		.selVals(selVals),
		.isConst(isConst)
	);

	// ex3 bypass covers the write until the bank catches up next cycle
	forwardNet fwdNet
	(
		.readIds(readIds),
		.selVals(selVals),
		.isConst(isConst),
		.ex1(ex1),
		.ex2(ex2),
		.ex3(ex3),
		.readVals(readVals)
	);

endmodule

// ==== verif/regFileTb.sv ====
`timescale 1ns/1ps

module regFileTb import gprPkg::*;
();

	localparam int halfPeriod = 10;	// 20 ns clock
	localparam int settle = 2;	// comb read path settles well before the next rise
	localparam int cycleBudget = 1000;	// tests use ~125 cycles, lots of margin
	localparam int watchdogLimit = cycleBudget * 2 * halfPeriod;	// 20 us
	localparam int slotCount = 3 * laneCount;	// ex1..ex3 times lanes A..C

	logic clock;
	logic rstN;
	logic hold;
	logic ex3Flush;
	portIds_t readIds;
	laneImms_t laneImms;
	stageWrites_t ex1;
	stageWrites_t ex2;
	stageWrites_t ex3;
	portVals_t readVals;

	logic [gprWidth-1:0] model [gprCount];	// expected register contents
	integer seed;
	int checkCount;
	int errCount;
	int testCount;
	int badTests;

	regFile6r3w regFile6r3w_i
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.ex3Flush(ex3Flush),
		.readIds(readIds),
		.laneImms(laneImms),
		.ex1(ex1),
		.ex2(ex2),
		.ex3(ex3),
		.readVals(readVals)
	);

	initial
	begin
		clock = 1'b0;
		forever #halfPeriod clock = ~clock;
	end

	function automatic gprId_t idOf(input logic [idxWidth:0] raw);
		gprId_t id;

		id.raw = raw;
		return id;
	endfunction

	// all ids zzr means nothing in flight
	function automatic stageWrites_t idleStage();
		stageWrites_t st;

		for (int l = 0; l < laneCount; l++)
		begin
			st[l].id = idOf(gprIdZzr);
			st[l].val = '0;
		end
		return st;
	endfunction

	function automatic logic [gprWidth-1:0] randWord();
		return {$random(seed), $random(seed)};
	endfunction

	// bit 32 set gives ones in the top half
	function automatic logic [gprWidth-1:0] signExt(input logic [immWidth-1:0] imm);
		return {{(gprWidth - 32){imm[32]}}, imm[31:0]};
	endfunction

	// what a port should read with no stage result in flight
	function automatic logic [gprWidth-1:0] expectRead(input int p, input gprId_t id);
		if (!id.fld.isSpecial)
			return model[id.fld.idx];
		else if (id.raw == gprIdImm)
			return signExt(laneImms[p / 2]);	// ports 2l, 2l+1 use lane l
		return '0;	// zzr and the other specials
	endfunction

	task automatic checkPort(input int p, input logic [gprWidth-1:0] exp, input string what);
		checkCount++;
		if (readVals[p] !== exp)
		begin
			errCount++;
			$display("FAIL t=%0t: %s, port %0d read %h, expected %h",
				$time, what, p, readVals[p], exp);
		end
	endtask

	task automatic endTest(input string name, input int errsBefore);
		testCount++;
		if (errCount == errsBefore)
			$display("test %s: ok", name);
		else
		begin
			badTests++;
			$display("test %s: %0d wrong values", name, errCount - errsBefore);
		end
	endtask

	// apply current ex3 to the model by the write rules, then cross one rising edge
	task automatic commitCycle();
		for (int l = 0; l < laneCount; l++)
		begin
			if (!hold && !ex3Flush && !ex3[l].id.fld.isSpecial)
				model[ex3[l].id.fld.idx] = ex3[l].val;	// later lane wins
		end
		@(negedge clock);
		ex3 = idleStage();
		hold = 1'b0;
		ex3Flush = 1'b0;
	endtask

	// stages must be idle, every port walks all 32 regs
	task automatic checkAllRegs(input string what);
		for (int base = 0; base < gprCount; base++)
		begin
			for (int p = 0; p < portCount; p++)
				readIds[p] = idOf(6'((base + p) % gprCount));
			#settle;
			for (int p = 0; p < portCount; p++)
				checkPort(p, expectRead(p, readIds[p]), what);
			@(negedge clock);
		end
	endtask

	task automatic setSlot(input int s, input gprId_t id, input logic [gprWidth-1:0] val);
		writeLane_t w;

		w.id = id;
		w.val = val;
		case (s / laneCount)
			0: ex1[s % laneCount] = w;	// youngest stage
			1: ex2[s % laneCount] = w;
			default: ex3[s % laneCount] = w;
		endcase
	endtask

	task automatic testReset();
		int errsBefore;

		errsBefore = errCount;
		checkAllRegs("reset sweep");
		for (int p = 0; p < portCount; p++)
			readIds[p] = idOf(gprIdZzr);
		#settle;
		for (int p = 0; p < portCount; p++)
			checkPort(p, '0, "zzr after reset");
		@(negedge clock);
		endTest("reset state", errsBefore);
	endtask

	task automatic testConstants();
		int errsBefore;

		errsBefore = errCount;
		for (int round = 0; round < 2; round++)
		begin
			for (int l = 0; l < laneCount; l++)
			begin
				laneImms[l] = {1'b0, $random(seed)};
				laneImms[l][32] = ((l + round) % 2 == 1);	// each lane sees both signs
				readIds[2 * l] = idOf(gprIdImm);
				readIds[2 * l + 1] = idOf(gprIdImm);
			end
			setSlot(0, idOf(gprIdImm), randWord());	// same id in flight, must be ignored
			#settle;
			for (int p = 0; p < portCount; p++)
				checkPort(p, signExt(laneImms[p / 2]), "lane immediate");
			@(negedge clock);
		end
		for (int p = 0; p < portCount; p++)
			readIds[p] = idOf(6'h20 + 6'(p));	// specials other than imm and zzr
		setSlot(0, idOf(6'h20), randWord());
		setSlot(4, idOf(6'h23), randWord());
		#settle;
		for (int p = 0; p < portCount; p++)
			checkPort(p, '0, "other special id");
		@(negedge clock);
		for (int p = 0; p < portCount; p++)
			readIds[p] = idOf(gprIdZzr);
		setSlot(1, idOf(gprIdZzr), randWord());
		#settle;
		for (int p = 0; p < portCount; p++)
			checkPort(p, '0, "zzr with zzr in flight");
		@(negedge clock);
		ex1 = idleStage();
		ex2 = idleStage();
		endTest("constant decode", errsBefore);
	endtask

	task automatic testWriteback();
		int errsBefore;
		int regs [laneCount];

		errsBefore = errCount;
		regs = '{3, 17, 30};
		for (int l = 0; l < laneCount; l++)
			setSlot(2 * laneCount + l, idOf(6'(regs[l])), randWord());
		readIds[0] = idOf(6'(regs[0]));
		#settle;
		checkPort(0, ex3[0].val, "ex3 bypass in write cycle");
		commitCycle();
		for (int p = 0; p < portCount; p++)
			readIds[p] = idOf(6'(regs[p % laneCount]));
		#settle;
		for (int p = 0; p < portCount; p++)
			checkPort(p, expectRead(p, readIds[p]), "lane readback");
		@(negedge clock);
		setSlot(7, idOf(6'd5), randWord());	// r5 from lane B
		commitCycle();
		setSlot(6, idOf(6'd5), randWord());	// then from lane A
		commitCycle();
		for (int l = 0; l < laneCount; l++)
			setSlot(6 + l, idOf(6'd7), randWord());	// three-way collision on r7
		commitCycle();
		for (int p = 0; p < portCount; p++)
			readIds[p] = idOf((p % 2 == 0) ? 6'd5 : 6'd7);
		#settle;
		for (int p = 0; p < portCount; p++)
			checkPort(p, expectRead(p, readIds[p]), "overwrite and collision");
		@(negedge clock);
		checkAllRegs("writeback sweep");
		endTest("writeback", errsBefore);
	endtask

	task automatic testGates();
		int errsBefore;

		errsBefore = errCount;
		setSlot(6, idOf(6'd9), randWord());	// known old value in r9
		commitCycle();
		setSlot(6, idOf(6'd9), randWord());
		hold = 1'b1;
		commitCycle();
		setSlot(8, idOf(6'd9), randWord());
		ex3Flush = 1'b1;
		commitCycle();
		setSlot(7, idOf(6'h29), randWord());	// special id, same low index as r9
		commitCycle();
		for (int p = 0; p < portCount; p++)
			readIds[p] = idOf(6'd9);
		#settle;
		for (int p = 0; p < portCount; p++)
			checkPort(p, expectRead(p, readIds[p]), "blocked write");
		@(negedge clock);
		checkAllRegs("gate sweep");
		endTest("write gates", errsBefore);
	endtask

	task automatic testForward();
		int errsBefore;
		logic [gprWidth-1:0] slotVal [slotCount];

		errsBefore = errCount;
		setSlot(6, idOf(6'd12), randWord());
		setSlot(7, idOf(6'd13), randWord());
		commitCycle();
		for (int s = 0; s < slotCount; s++)
			slotVal[s] = randWord();
		// drop the top slot each step, the next one in priority order must show
		for (int k = 0; k <= slotCount; k++)
		begin
			hold = 1'b1;	// keeps ex3 r12 out of the banks
			for (int s = 0; s < slotCount; s++)
				setSlot(s, (s < k) ? idOf(gprIdZzr) : idOf(6'd12), slotVal[s]);
			for (int p = 0; p < portCount; p++)
				readIds[p] = idOf((p % 2 == 0) ? 6'd12 : 6'd13);
			#settle;
			for (int p = 0; p < portCount; p++)
				checkPort(p, (p % 2 == 0 && k < slotCount) ? slotVal[k] :
					expectRead(p, readIds[p]), "forward priority");
			@(negedge clock);
		end
		ex1 = idleStage();
		ex2 = idleStage();
		ex3 = idleStage();
		hold = 1'b0;
		endTest("forwarding", errsBefore);
	endtask

	initial
	begin
		seed = 44472;
		checkCount = 0;
		errCount = 0;
		testCount = 0;
		badTests = 0;
		rstN = 1'b0;
		hold = 1'b0;
		ex3Flush = 1'b0;
		laneImms = '0;
		ex1 = idleStage();
		ex2 = idleStage();
		ex3 = idleStage();
		for (int p = 0; p < portCount; p++)
			readIds[p] = idOf(gprIdZzr);
		for (int r = 0; r < gprCount; r++)
			model[r] = '0;	// reset clears every register
		repeat (3) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		testReset();
		testConstants();
		testWriteback();
		testGates();
		testForward();
		$display("%0d tests, %0d with errors, %0d checks, %0d wrong values",
			testCount, badTests, checkCount, errCount);
		if (errCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		#watchdogLimit;
		$display("timeout: tests did not finish within %0d ns", watchdogLimit);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
src/gprPkg.sv
src/gprLiveTable.sv
src/gprBankFile.sv
src/operandSelect.sv
src/forwardNet.sv
src/regFile6r3w.sv
verif/regFileTb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module regFileTb -o regFileSim \
	|| { echo "build failed"; exit 1; }
./obj_dir/regFileSim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
